// File: source/imuldiv_pkg.sv
/* shared types and constants of the iterative multiply/divide unit
   imported by every RTL block and by the testbench */
package imuldiv_pkg;

  // ------------------------------
  // widths and step count
  // ------------------------------
  localparam int OPERAND_W  = 32;
  localparam int RESULT_W   = 2 * OPERAND_W;
  localparam int ITER_COUNT = 32;
  // step counter runs ITER_COUNT-1 down to 0
  localparam int CNT_W      = $clog2(ITER_COUNT);

  // function codes carried on the request
  typedef enum logic [1:0] {
    MD_MUL  = 2'd0,  // signed product, all 64 bits
    MD_DIV  = 2'd1,  // signed quotient and remainder
    MD_DIVU = 2'd2   // unsigned quotient and remainder
  } md_fn_e;

  // ------------------------------
  // request and response
  // ------------------------------
  typedef struct packed {
    md_fn_e               fn;
    logic [OPERAND_W-1:0] a;
    logic [OPERAND_W-1:0] b;
  } md_req_t;

  // multiply returns the product
  // divide returns remainder in the upper half, quotient in the lower half
  typedef logic [RESULT_W-1:0] md_result_t;

  // ------------------------------
  // multiply control and status
  // ------------------------------
  // sel low loads the operands, sel high takes the shifted value
  typedef struct packed {
    logic a_en;
    logic a_sel;
    logic b_en;
    logic b_sel;
    logic result_en;
    logic count_en;
  } mul_ctrl_t;

  typedef struct packed {
    logic counter_is_zero;
    logic b_lsb;
  } mul_status_t;

endpackage

// File: source/int_mul_iterative_dpath.sv
/* shift/add datapath of the iterative multiplier
   works on operand magnitudes, the control unit sequences it */
module int_mul_iterative_dpath (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [imuldiv_pkg::OPERAND_W-1:0] a,
  input  logic [imuldiv_pkg::OPERAND_W-1:0] b,
  input  imuldiv_pkg::mul_ctrl_t          ctrl,
  output imuldiv_pkg::mul_status_t        status,
  output imuldiv_pkg::md_result_t         result
);
  import imuldiv_pkg::*;

  logic [OPERAND_W-1:0] a_mag;
  logic [OPERAND_W-1:0] b_mag;
  logic [RESULT_W-1:0]  a_q;
  logic [OPERAND_W-1:0] b_q;
  logic [RESULT_W-1:0]  prod_q;
  logic [CNT_W-1:0]     count_q;
  logic                 neg_q;
  logic [RESULT_W-1:0]  a_next;
  logic [OPERAND_W-1:0] b_next;
  logic [RESULT_W-1:0]  prod_next;
  logic [CNT_W-1:0]     count_next;

  // ------------------------------
  // operand magnitudes
  // ------------------------------
  // most negative value maps to 2**31, still fits unsigned
  assign a_mag = a[OPERAND_W-1] ? -a : a;
  assign b_mag = b[OPERAND_W-1] ? -b : b;

  // load muxes versus shift paths
  assign a_next = ctrl.a_sel ? (a_q << 1) : {{OPERAND_W{1'b0}}, a_mag};
  assign b_next = ctrl.b_sel ? (b_q >> 1) : b_mag;

  // partial product accumulates only in step mode
  assign prod_next = ctrl.a_sel ? (prod_q + a_q) : '0;

  assign count_next = ctrl.a_sel ? (count_q - 1'b1) : CNT_W'(ITER_COUNT - 1);

  // operand and product registers
  always_ff @(posedge clk) begin
    if (ctrl.a_en) begin
      a_q <= a_next;
    end
    if (ctrl.b_en) begin
      b_q <= b_next;
    end
    if (ctrl.result_en) begin
      prod_q <= prod_next;
    end
  end

  // counter and product sign
  always_ff @(posedge clk) begin
    if (reset) begin
      count_q <= '0;
      neg_q   <= 1'b0;
    end else begin
      if (ctrl.count_en) begin
        count_q <= count_next;
      end
      // sign captured together with the operand load
      if (ctrl.a_en && !ctrl.a_sel) begin
        neg_q <= a[OPERAND_W-1] ^ b[OPERAND_W-1];
      end
    end
  end

  assign status.counter_is_zero = (count_q == '0);
  assign status.b_lsb           = b_q[0];

  // sign fixup straight from registered values
  assign result = neg_q ? -prod_q : prod_q;

endmodule

// File: source/int_mul_iterative_ctrl.sv
/* three-state control unit of the iterative multiplier
   drives the datapath enables/selects and the valid/ready handshake */
module int_mul_iterative_ctrl (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_val,
  output logic                     req_rdy,
  output logic                     resp_val,
  input  logic                     resp_rdy,
  output imuldiv_pkg::mul_ctrl_t   ctrl,
  input  imuldiv_pkg::mul_status_t status
);
  import imuldiv_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CALC,
    ST_DONE
  } state_e;

  state_e state_q;
  logic   load;

  assign load = req_rdy && req_val;

  // ------------------------------
  // state register
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: if (load) state_q <= ST_CALC;
        // last step is the one that saw the counter at zero
        ST_CALC: if (status.counter_is_zero) state_q <= ST_DONE;
        ST_DONE: if (resp_rdy) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // ------------------------------
  // datapath controls
  // ------------------------------
  always_comb begin
    ctrl     = '0;
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    case (state_q)
      ST_IDLE: begin
        req_rdy        = 1'b1;
        // all sels low, so operands load and product clears
        ctrl.a_en      = load;
        ctrl.b_en      = load;
        ctrl.result_en = load;
        ctrl.count_en  = load;
      end
      ST_CALC: begin
        ctrl.a_en      = 1'b1;
        ctrl.a_sel     = 1'b1;
        ctrl.b_en      = 1'b1;
        ctrl.b_sel     = 1'b1;
        // add shifted a only where the multiplier bit is set
        ctrl.result_en = status.b_lsb;
        ctrl.count_en  = 1'b1;
      end
      ST_DONE: begin
        resp_val = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// File: source/int_div_iterative.sv
/* restoring divider, one quotient bit per cycle
   signed or unsigned by function code, result is {remainder, quotient} */
module int_div_iterative (
  input  logic                    clk,
  input  logic                    reset,
  input  imuldiv_pkg::md_req_t    req,
  input  logic                    req_val,
  output logic                    req_rdy,
  output logic                    resp_val,
  input  logic                    resp_rdy,
  output imuldiv_pkg::md_result_t result
);
  import imuldiv_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CALC,
    ST_DONE
  } state_e;

  state_e               state_q;
  logic [CNT_W-1:0]     count_q;
  logic [OPERAND_W-1:0] quo_q;
  logic [OPERAND_W-1:0] rem_q;
  logic [OPERAND_W-1:0] dvs_q;
  logic                 quo_neg_q;
  logic                 rem_neg_q;
  logic                 load;
  logic                 is_signed;
  logic                 a_neg;
  logic                 b_neg;
  logic [OPERAND_W-1:0] a_mag;
  logic [OPERAND_W-1:0] b_mag;
  logic [OPERAND_W:0]   partial;
  logic [OPERAND_W:0]   diff;
  logic                 fits;
  logic [OPERAND_W-1:0] quo_out;
  logic [OPERAND_W-1:0] rem_out;

  assign req_rdy  = (state_q == ST_IDLE);
  assign resp_val = (state_q == ST_DONE);
  assign load     = req_rdy && req_val;

  // ------------------------------
  // magnitudes and signs
  // ------------------------------
  assign is_signed = (req.fn == MD_DIV);
  assign a_neg     = is_signed && req.a[OPERAND_W-1];
  assign b_neg     = is_signed && req.b[OPERAND_W-1];
  assign a_mag     = a_neg ? -req.a : req.a;
  assign b_mag     = b_neg ? -req.b : req.b;

  // ------------------------------
  // one restoring step
  // ------------------------------
  // remainder shifted left, next dividend bit brought in
  assign partial = {rem_q, quo_q[OPERAND_W-1]};
  assign diff    = partial - {1'b0, dvs_q};
  // no borrow means the divisor fits
  assign fits    = !diff[OPERAND_W];

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ST_IDLE;
      count_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (load) begin
            state_q <= ST_CALC;
            count_q <= CNT_W'(ITER_COUNT - 1);
          end
        end
        ST_CALC: begin
          count_q <= count_q - 1'b1;
          if (count_q == '0) state_q <= ST_DONE;
        end
        ST_DONE: if (resp_rdy) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // quotient shares its register with the dividend
  always_ff @(posedge clk) begin
    if (load) begin
      quo_q     <= a_mag;
      rem_q     <= '0;
      dvs_q     <= b_mag;
      // divide by zero keeps an all-ones quotient unsigned
      quo_neg_q <= (a_neg ^ b_neg) && (req.b != '0);
      // remainder follows the dividend
      rem_neg_q <= a_neg;
    end else if (state_q == ST_CALC) begin
      quo_q <= {quo_q[OPERAND_W-2:0], fits};
      rem_q <= fits ? diff[OPERAND_W-1:0] : partial[OPERAND_W-1:0];
    end
  end

  // most negative / -1 wraps back to itself through the negation
  assign quo_out = quo_neg_q ? -quo_q : quo_q;
  assign rem_out = rem_neg_q ? -rem_q : rem_q;
  assign result  = {rem_out, quo_out};

endmodule

// File: source/imuldiv_unit.sv
/* top of the multiply/divide unit, one request in flight at a time
   registers the request, steers it by function code and merges responses */
module imuldiv_unit (
  input  logic                    clk,
  input  logic                    reset,
  input  imuldiv_pkg::md_req_t    req,
  input  logic                    req_val,
  output logic                    req_rdy,
  output imuldiv_pkg::md_result_t resp,
  output logic                    resp_val,
  input  logic                    resp_rdy
);
  import imuldiv_pkg::*;

  md_req_t     req_q;
  logic        issue_q;
  mul_ctrl_t   mul_ctrl;
  mul_status_t mul_status;
  md_result_t  mul_result;
  md_result_t  div_result;
  logic        mul_req_val;
  logic        mul_req_rdy;
  logic        mul_resp_val;
  logic        mul_resp_rdy;
  logic        div_req_val;
  logic        div_req_rdy;
  logic        div_resp_val;
  logic        div_resp_rdy;

  // ------------------------------
  // accept and issue
  // ------------------------------
  // both engines idle and nothing waiting to be issued
  assign req_rdy = mul_req_rdy && div_req_rdy && !issue_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      issue_q <= 1'b0;
    end else begin
      issue_q <= req_val && req_rdy;
    end
  end

  always_ff @(posedge clk) begin
    if (req_val && req_rdy) begin
      req_q <= req;
    end
  end

  // anything other than multiply goes to the divider
  assign mul_req_val = issue_q && (req_q.fn == MD_MUL);
  assign div_req_val = issue_q && (req_q.fn != MD_MUL);

  int_mul_iterative_dpath u_mul_dpath (
    .clk    (clk),
    .reset  (reset),
    .a      (req_q.a),
    .b      (req_q.b),
    .ctrl   (mul_ctrl),
    .status (mul_status),
    .result (mul_result)
  );

  int_mul_iterative_ctrl u_mul_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy),
    .ctrl     (mul_ctrl),
    .status   (mul_status)
  );

  int_div_iterative u_div (
    .clk      (clk),
    .reset    (reset),
    .req      (req_q),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy),
    .result   (div_result)
  );

  // ------------------------------
  // response merge
  // ------------------------------
  // at most one engine is ever done
  assign resp_val     = mul_resp_val || div_resp_val;
  assign resp         = div_resp_val ? div_result : mul_result;
  assign mul_resp_rdy = resp_rdy && mul_resp_val;
  assign div_resp_rdy = resp_rdy && div_resp_val;

endmodule

// File: tests/imuldiv_props.sv
/* handshake assertions of the multiply/divide unit
   bound into the unit by the testbench */
module imuldiv_props (
  input logic                    clk,
  input logic                    reset,
  input logic                    req_rdy,
  input logic                    resp_val,
  input logic                    resp_rdy,
  input imuldiv_pkg::md_result_t resp
);

  // ------------------------------
  // response side
  // ------------------------------
  // a waiting response neither drops nor changes
  resp_held_a: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp))
    else $error("response dropped or changed before resp_rdy");

  // single outstanding, no accept while a response waits
  busy_rdy_a: assert property (@(posedge clk) disable iff (reset)
    resp_val |-> !req_rdy)
    else $error("req_rdy high while a response is pending");

  // nothing comes out straight after reset
  reset_quiet_a: assert property (@(posedge clk)
    reset |=> !resp_val)
    else $error("resp_val high in the cycle after reset");

endmodule

// File: tests/imuldiv_tb.sv
/* testbench of the multiply/divide unit
   replays the requests of the testdata file and checks each response */
module imuldiv_tb;
  import imuldiv_pkg::*;

  localparam int    CLK_PERIOD   = 8;
  localparam int    RESET_CYCLES = 4;
  // edges from the accepting edge to the first resp_val
  localparam int    LATENCY      = 33;
  localparam int    WAIT_LIMIT   = 200;
  localparam string DATA_FILE    = "tests/imuldiv_testdata.txt";

  logic       clk;
  logic       reset;
  md_req_t    req;
  logic       req_val;
  logic       req_rdy;
  md_result_t resp;
  logic       resp_val;
  logic       resp_rdy;
  integer     seed;

  imuldiv_unit u_dut (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  // handshake assertions inside every unit instance
  bind imuldiv_unit imuldiv_props u_props (
    .clk      (clk),
    .reset    (reset),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp     (resp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ------------------------------
  // error reporting and compares
  // ------------------------------
  task automatic report_failure(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_result(input string name, input md_result_t expected,
                              input md_result_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      report_failure($sformatf("ERROR %s: expected %b, actual %b", name, expected, actual));
    end
  endtask

  // ------------------------------
  // one request and its response
  // ------------------------------
  task automatic run_case(input string name, input md_req_t request,
                          input md_result_t expected);
    int   cycles;
    logic done;
    cycles = 0;
    while (req_rdy !== 1'b1 && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (req_rdy !== 1'b1) begin
      report_failure({name, ": the unit never became ready for a request"});
    end
    req     = request;
    req_val = 1'b1;
    // accepting edge
    @(posedge clk);
    #1;
    req_val = 1'b0;
    req     = '0;
    // resp_val must rise on exactly the fixed edge, unit stays busy meanwhile
    cycles = 0;
    do begin
      @(posedge clk);
      #1;
      cycles++;
      check_flag({name, " resp_val timing"}, logic'(cycles == LATENCY), resp_val);
      check_flag({name, " req_rdy while busy"}, 1'b0, req_rdy);
    end while (resp_val !== 1'b1 && cycles < WAIT_LIMIT);
    if (resp_val !== 1'b1) begin
      report_failure({name, ": no response arrived in time"});
    end
    // random back-pressure, response must hold until taken
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < WAIT_LIMIT) begin
      resp_rdy = (($random(seed) & 3) != 0);
      check_flag({name, " resp_val held"}, 1'b1, resp_val);
      check_result({name, " resp"}, expected, resp);
      done = resp_rdy;
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!done) begin
      report_failure({name, ": the response was never taken"});
    end
    resp_rdy = 1'b0;
    // exactly one response per request
    check_flag({name, " resp_val after transfer"}, 1'b0, resp_val);
    check_flag({name, " req_rdy after transfer"}, 1'b1, req_rdy);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    integer     fd;
    string      line;
    logic [1:0] fn_bits;
    md_fn_e     fn;
    logic [OPERAND_W-1:0] a_val;
    logic [OPERAND_W-1:0] b_val;
    md_result_t expected;
    md_req_t    request;
    int         line_no;
    int         cases;
    seed     = 15;
    reset    = 1'b1;
    req      = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    line_no  = 0;
    cases    = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
    check_flag("reset req_rdy", 1'b1, req_rdy);
    check_flag("reset resp_val", 1'b0, resp_val);

    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      report_failure("the test data file could not be opened");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      line_no++;
      // blank lines and # comments carry no request
      if (line.len() > 1 && line.getc(0) != "#") begin
        if ($sscanf(line, "%h %h %h %h", fn_bits, a_val, b_val, expected) != 4) begin
          report_failure($sformatf("line %0d of the test data file is malformed", line_no));
        end
        fn         = md_fn_e'(fn_bits);
        request.fn = fn;
        request.a  = a_val;
        request.b  = b_val;
        run_case($sformatf("line %0d %s", line_no, fn.name()), request, expected);
        cases++;
      end
    end
    $fclose(fd);

    if (cases == 0) begin
      report_failure("no requests were found in the test data file");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

// File: tests/imuldiv_testdata.txt
# fn (0 mul, 1 div, 2 divu)  operand a  operand b  expected result, all hex
# divide results hold the remainder in the upper half, the quotient in the lower half
0 00000007 00000006 000000000000002a
0 00000003 fffffffb fffffffffffffff1
0 fffffffe ffffffff 0000000000000002
0 00000000 12345678 0000000000000000
0 80000000 80000000 4000000000000000
0 80000000 00000001 ffffffff80000000
0 7fffffff 7fffffff 3fffffff00000001
0 80000000 ffffffff 0000000080000000
1 00000014 00000003 0000000200000006
1 ffffffec 00000003 fffffffefffffffa
1 00000014 fffffffd 00000002fffffffa
1 ffffffec fffffffd fffffffe00000006
1 00000007 00000000 00000007ffffffff
1 fffffff9 00000000 fffffff9ffffffff
1 80000000 ffffffff 0000000080000000
2 ffffffec 00000003 000000025555554e
2 00000064 00000000 00000064ffffffff
2 deadbeef 00001000 00000eef000deadb
2 80000000 ffffffff 8000000000000000

// File: project.f
source/imuldiv_pkg.sv
source/int_mul_iterative_dpath.sv
source/int_mul_iterative_ctrl.sv
source/int_div_iterative.sv
source/imuldiv_unit.sv
tests/imuldiv_props.sv
tests/imuldiv_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the multiply/divide testbench with Verilator and run it
# exit status is non-zero when the log shows a failure or no pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module imuldiv_tb \
  -f project.f -o imuldiv_sim \
  && ./obj_dir/imuldiv_sim > sim.log 2>&1 \
  || echo "build or simulation ended with an error" >> sim.log

cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || exit 1
exit 0
